//--- src.f
+incdir+common
common/sched_pkg.sv
hdl/request_intake.sv
hdl/request_queue.sv
cmd_issue/bank_tracker.sv
cmd_issue/command_sequencer.sv
hdl/request_scheduler.sv
tb/tb_request_scheduler.sv

//--- Bender.yml
package:
  name: request_scheduler

sources:
  - include_dirs:
      - common
    files:
      - common/sched_pkg.sv
      - hdl/request_intake.sv
      - hdl/request_queue.sv
      - cmd_issue/bank_tracker.sv
      - cmd_issue/command_sequencer.sv
      - hdl/request_scheduler.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_request_scheduler.sv

//--- tb/tb_request_scheduler.sv
`include "sched_cfg.svh"

module tb_request_scheduler;

    localparam int NUM_REQ        = 45; // 1 + 1 + 1 + 30 + 1 + 11 requests over all tests
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 200;

    // one expected command as the model predicts it
    typedef struct packed {
        logic [2:0]                  cmd;
        logic [`SCHED_BG_BITS-1:0]   bg;
        logic [`SCHED_BANK_BITS-1:0] bk;
        logic [`SCHED_ROW_BITS-1:0]  row;
        logic [`SCHED_COL_BITS-1:0]  col;
        logic [`SCHED_DATA_BITS-1:0] data;
    } exp_cmd_t;

    logic                         clk_in;
    logic                         rst_in;
    logic                         valid_in;
    logic [`SCHED_BG_BITS-1:0]    bank_group_in;
    logic [`SCHED_BANK_BITS-1:0]  bank_in;
    logic [`SCHED_ROW_BITS-1:0]   row_in;
    logic [`SCHED_COL_BITS-1:0]   col_in;
    logic                         write_in;
    logic [`SCHED_DATA_BITS-1:0]  val_in;
    logic                         cmd_ready;
    logic                         valid_out;
    logic [2:0]                   cmd_out;
    logic [`SCHED_BG_BITS-1:0]    bank_group_out;
    logic [`SCHED_BANK_BITS-1:0]  bank_out;
    logic [`SCHED_ROW_BITS-1:0]   row_out;
    logic [`SCHED_COL_BITS-1:0]   col_out;
    logic [`SCHED_DATA_BITS-1:0]  val_out;
    logic [7:0]                   dropped_count;

    exp_cmd_t                   exp_q[$];
    logic                       model_open [`SCHED_BANKS];
    logic [`SCHED_ROW_BITS-1:0] model_row [`SCHED_BANKS];
    logic [31:0]                lcg_state = 32'd76251;
    logic [2:0]                 last_cmd = `SCHED_CMD_READ;
    int                         last_cycle = 0;
    int                         err_count = 0;
    int                         cycle_count = 0;
    int                         cmd_seen = 0;
    int                         model_drops = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;

    request_scheduler request_scheduler_inst (
        .clk_in(clk_in), .rst_in(rst_in), .valid_in(valid_in),
        .bank_group_in(bank_group_in), .bank_in(bank_in), .row_in(row_in),
        .col_in(col_in), .write_in(write_in), .val_in(val_in), .cmd_ready(cmd_ready),
        .valid_out(valid_out), .cmd_out(cmd_out), .bank_group_out(bank_group_out),
        .bank_out(bank_out), .row_out(row_out), .col_out(col_out), .val_out(val_out),
        .dropped_count(dropped_count)
    );

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d commands never came", cycle_count,
                     exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // no command may leave in a cycle decided while cmd_ready was low
    stall_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
                                  !$past(cmd_ready) |-> !valid_out)
        else begin
            $display("[FAIL] %0t valid_out went high while cmd_ready was low", $time);
            err_count++;
        end

    write_data_only: assert property (@(posedge clk_in) disable iff (rst_in)
                                      (valid_out && cmd_out != `SCHED_CMD_WRITE) |-> val_out == '0)
        else begin
            $display("[FAIL] %0t val_out expected 0 got %0h", $time, $sampled(val_out));
            err_count++;
        end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // each command out is matched against the model's next expected one
    always @(negedge clk_in) begin
        exp_cmd_t e;
        if (!rst_in && valid_out) begin
            cmd_seen++;
            if (exp_q.size() == 0) begin
                $display("[FAIL] %0t command %0d issued with no request pending", $time, cmd_out);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                check_field("cmd_out", e.cmd, cmd_out);
                check_field("bank_group_out", e.bg, bank_group_out);
                check_field("bank_out", e.bk, bank_out);
                if (e.cmd != `SCHED_CMD_PRECHARGE) check_field("row_out", e.row, row_out);
                if (e.cmd <= `SCHED_CMD_WRITE) check_field("col_out", e.col, col_out);
                check_field("val_out", e.data, val_out);
            end
            if (cmd_out == `SCHED_CMD_ACTIVATE && last_cmd == `SCHED_CMD_PRECHARGE)
                assert (cycle_count - last_cycle >= `SCHED_PRE_LATENCY) else begin
                    $display("[FAIL] %0t activate only %0d cycles after precharge", $time,
                             cycle_count - last_cycle);
                    err_count++;
                end
            if (cmd_out <= `SCHED_CMD_WRITE && last_cmd == `SCHED_CMD_ACTIVATE)
                assert (cycle_count - last_cycle >= `SCHED_ACT_LATENCY) else begin
                    $display("[FAIL] %0t access only %0d cycles after activate", $time,
                             cycle_count - last_cycle);
                    err_count++;
                end
            last_cmd   = cmd_out;
            last_cycle = cycle_count;
        end
    end

    // a closed bank gets an activate first and a row miss gets precharge and activate
    task automatic predict(input logic [`SCHED_BG_BITS-1:0] bg,
                           input logic [`SCHED_BANK_BITS-1:0] bk,
                           input logic [`SCHED_ROW_BITS-1:0] row,
                           input logic [`SCHED_COL_BITS-1:0] col,
                           input logic wr, input logic [`SCHED_DATA_BITS-1:0] data);
        int       idx;
        exp_cmd_t e;
        idx    = bg * `SCHED_BANKS_PER_GROUP + bk;
        e.bg   = bg;
        e.bk   = bk;
        e.row  = row;
        e.col  = col;
        e.data = '0;
        if (!model_open[idx]) begin
            e.cmd = `SCHED_CMD_ACTIVATE;
            exp_q.push_back(e);
        end else if (model_row[idx] != row) begin
            e.cmd = `SCHED_CMD_PRECHARGE;
            exp_q.push_back(e);
            e.cmd = `SCHED_CMD_ACTIVATE;
            exp_q.push_back(e);
        end
        e.cmd  = wr ? `SCHED_CMD_WRITE : `SCHED_CMD_READ;
        e.data = wr ? data : '0;
        exp_q.push_back(e);
        model_open[idx] = 1'b1;
        model_row[idx]  = row;
    endtask

    task automatic send_req(input logic [`SCHED_BG_BITS-1:0] bg,
                            input logic [`SCHED_BANK_BITS-1:0] bk,
                            input logic [`SCHED_ROW_BITS-1:0] row,
                            input logic [`SCHED_COL_BITS-1:0] col,
                            input logic wr, input logic [`SCHED_DATA_BITS-1:0] data,
                            input bit accept);
        @(negedge clk_in);
        valid_in      = 1'b1;
        bank_group_in = bg;
        bank_in       = bk;
        row_in        = row;
        col_in        = col;
        write_in      = wr;
        val_in        = data;
        if (accept) predict(bg, bk, row, col, wr, data);
        else model_drops++;
    endtask

    task automatic send_random(input bit accept);
        logic [31:0] r;
        r = lcg_next();
        // rows limited to four values so hits and misses both come up
        send_req(r[31], r[30], `SCHED_ROW_BITS'(r[29:28]), r[27:24], r[23], lcg_next(), accept);
    endtask

    task automatic release_input();
        @(negedge clk_in);
        valid_in = 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge clk_in);
        while (exp_q.size() != 0) @(posedge clk_in);
        repeat (4) @(posedge clk_in); // room for a stray extra command to show up
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
        end
    endtask

    initial begin
        int                         errs;
        int                         seen;
        logic [`SCHED_ROW_BITS-1:0] row_a;
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        valid_in      = 1'b0;
        bank_group_in = '0;
        bank_in       = '0;
        row_in        = '0;
        col_in        = '0;
        write_in      = 1'b0;
        val_in        = '0;
        cmd_ready     = 1'b1;
        for (int i = 0; i < `SCHED_BANKS; i++) begin
            model_open[i] = 1'b0;
            model_row[i]  = '0;
        end
        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;

        errs = err_count;
        check_field("valid_out", 0, valid_out);
        check_field("dropped_count", 0, dropped_count);
        row_a = `SCHED_ROW_BITS'(lcg_next() >> 24);
        send_req(1'b0, 1'b0, row_a, 4'd3, 1'b1, lcg_next(), 1'b1);
        release_input();
        wait_drain();
        end_test(1, "write to closed bank", errs);

        errs = err_count;
        send_req(1'b0, 1'b0, row_a, 4'd9, 1'b0, lcg_next(), 1'b1); // data on a read must not show
        release_input();
        wait_drain();
        end_test(2, "read row hit", errs);

        errs = err_count;
        send_req(1'b0, 1'b0, row_a + 8'd1, 4'd5, 1'b0, lcg_next(), 1'b1);
        release_input();
        wait_drain();
        end_test(3, "row miss", errs);

        errs = err_count;
        for (int b = 0; b < 10; b++) begin
            for (int k = 0; k < 3; k++) send_random(1'b1);
            release_input();
            wait_drain();
        end
        end_test(4, "random requests", errs);

        errs = err_count;
        send_req(1'b1, 1'b1, model_row[3] + 8'd1, 4'd7, 1'b1, lcg_next(), 1'b1);
        release_input();
        seen = cmd_seen + 1;
        while (cmd_seen < seen) @(posedge clk_in);
        @(negedge clk_in);
        cmd_ready = 1'b0;
        repeat (16) @(posedge clk_in);
        assert (cmd_seen == seen) else begin
            $display("[FAIL] %0t commands went out while cmd_ready was low", $time);
            err_count++;
        end
        @(negedge clk_in);
        cmd_ready = 1'b1;
        wait_drain();
        end_test(5, "cmd_ready stall", errs);

        errs = err_count;
        @(negedge clk_in);
        cmd_ready = 1'b0;
        for (int i = 0; i < `SCHED_QUEUE_DEPTH + 3; i++) send_random(i < `SCHED_QUEUE_DEPTH);
        release_input();
        repeat (4) @(negedge clk_in);
        check_field("dropped_count", model_drops, dropped_count);
        cmd_ready = 1'b1;
        wait_drain();
        end_test(6, "full queue drops", errs);

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/request_scheduler.sv
`include "sched_cfg.svh"

module request_scheduler import sched_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         valid_in,
    input  logic [`SCHED_BG_BITS-1:0]    bank_group_in,
    input  logic [`SCHED_BANK_BITS-1:0]  bank_in,
    input  logic [`SCHED_ROW_BITS-1:0]   row_in,
    input  logic [`SCHED_COL_BITS-1:0]   col_in,
    input  logic                         write_in,
    input  logic [`SCHED_DATA_BITS-1:0]  val_in,
    input  logic                         cmd_ready,
    output logic                         valid_out,
    output logic [2:0]                   cmd_out,
    output logic [`SCHED_BG_BITS-1:0]    bank_group_out,
    output logic [`SCHED_BANK_BITS-1:0]  bank_out,
    output logic [`SCHED_ROW_BITS-1:0]   row_out,
    output logic [`SCHED_COL_BITS-1:0]   col_out,
    output logic [`SCHED_DATA_BITS-1:0]  val_out,
    output logic [7:0]                   dropped_count
);

    // intake to queue
    logic                        push;
    sched_addr_u                 push_addr;
    logic                        push_write;
    logic [`SCHED_DATA_BITS-1:0] push_data;
    logic                        full;

    // queue to sequencer
    logic                        pop;
    logic                        empty;
    sched_addr_u                 head_addr;
    logic                        head_write;
    logic [`SCHED_DATA_BITS-1:0] head_data;

    request_intake request_intake_inst (
        .clk_in(clk_in), .rst_in(rst_in),
        .valid_in(valid_in), .bank_group_in(bank_group_in), .bank_in(bank_in),
        .row_in(row_in), .col_in(col_in), .write_in(write_in), .val_in(val_in),
        .full(full), .push(push), .push_addr(push_addr), .push_write(push_write),
        .push_data(push_data), .dropped_count(dropped_count)
    );

    request_queue request_queue_inst (
        .clk_in(clk_in), .rst_in(rst_in),
        .push(push), .push_addr(push_addr), .push_write(push_write), .push_data(push_data),
        .pop(pop), .full(full), .empty(empty),
        .head_addr(head_addr), .head_write(head_write), .head_data(head_data)
    );

    command_sequencer command_sequencer_inst (
        .clk_in(clk_in), .rst_in(rst_in), .cmd_ready(cmd_ready),
        .empty(empty), .head_addr(head_addr), .head_write(head_write),
        .head_data(head_data), .pop(pop), .valid_out(valid_out), .cmd_out(cmd_out),
        .bank_group_out(bank_group_out), .bank_out(bank_out),
        .row_out(row_out), .col_out(col_out), .val_out(val_out)
    );

endmodule

//--- cmd_issue/command_sequencer.sv
`include "sched_cfg.svh"

module command_sequencer import sched_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         cmd_ready,
    input  logic                         empty,
    input  sched_addr_u                  head_addr,
    input  logic                         head_write,
    input  logic [`SCHED_DATA_BITS-1:0]  head_data,
    output logic                         pop,
    output logic                         valid_out,
    output logic [2:0]                   cmd_out,
    output logic [`SCHED_BG_BITS-1:0]    bank_group_out,
    output logic [`SCHED_BANK_BITS-1:0]  bank_out,
    output logic [`SCHED_ROW_BITS-1:0]   row_out,
    output logic [`SCHED_COL_BITS-1:0]   col_out,
    output logic [`SCHED_DATA_BITS-1:0]  val_out
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_PRE_WAIT = 2'd1; // precharge sent, activate pending
    localparam logic [1:0] ST_ACT_WAIT = 2'd2; // activate sent, access pending

    localparam int LAT_BITS = $clog2(`SCHED_ACT_LATENCY > `SCHED_PRE_LATENCY ?
                                     `SCHED_ACT_LATENCY : `SCHED_PRE_LATENCY);

    logic [1:0]                 state_q;
    logic [1:0]                 state_d;
    logic [LAT_BITS-1:0]        lat_cnt;
    logic                       issue;
    logic [2:0]                 issue_cmd;
    logic                       open_strobe;
    logic                       close_strobe;
    logic                       bank_open;
    logic [`SCHED_ROW_BITS-1:0] open_row;
    logic [2:0]                 access_cmd;

    bank_tracker bank_tracker_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .open_strobe  (open_strobe),
        .close_strobe (close_strobe),
        .bank_idx     (head_addr.trk.bank_idx),
        .row          (head_addr.trk.row),
        .bank_open    (bank_open),
        .open_row     (open_row)
    );

    assign access_cmd = head_write ? `SCHED_CMD_WRITE : `SCHED_CMD_READ;

    always_comb begin
        issue        = 1'b0;
        issue_cmd    = `SCHED_CMD_READ;
        open_strobe  = 1'b0;
        close_strobe = 1'b0;
        pop          = 1'b0;
        state_d      = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!empty && cmd_ready) begin
                    issue = 1'b1;
                    if (!bank_open) begin // closed bank, open the row first
                        issue_cmd   = `SCHED_CMD_ACTIVATE;
                        open_strobe = 1'b1;
                        state_d     = ST_ACT_WAIT;
                    end else if (open_row != head_addr.trk.row) begin
                        issue_cmd    = `SCHED_CMD_PRECHARGE; // row miss
                        close_strobe = 1'b1;
                        state_d      = ST_PRE_WAIT;
                    end else begin
                        issue_cmd = access_cmd; // row hit
                        pop       = 1'b1;
                    end
                end
            end
            ST_PRE_WAIT: begin
                if (lat_cnt == '0 && cmd_ready) begin
                    issue       = 1'b1;
                    issue_cmd   = `SCHED_CMD_ACTIVATE;
                    open_strobe = 1'b1;
                    state_d     = ST_ACT_WAIT;
                end
            end
            ST_ACT_WAIT: begin
                if (lat_cnt == '0 && cmd_ready) begin
                    issue     = 1'b1;
                    issue_cmd = access_cmd;
                    pop       = 1'b1;
                    state_d   = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // loaded one short of the latency so the next decision lands exactly on it
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q <= ST_IDLE;
            lat_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (open_strobe) begin
                lat_cnt <= LAT_BITS'(`SCHED_ACT_LATENCY - 1);
            end else if (close_strobe) begin
                lat_cnt <= LAT_BITS'(`SCHED_PRE_LATENCY - 1);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1; // runs on even while cmd_ready is low
            end
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out      <= 1'b0;
            cmd_out        <= `SCHED_CMD_READ;
            bank_group_out <= '0;
            bank_out       <= '0;
            row_out        <= '0;
            col_out        <= '0;
            val_out        <= '0;
        end else begin
            valid_out <= issue;
            val_out   <= (issue && issue_cmd == `SCHED_CMD_WRITE) ? head_data : '0;
            if (issue) begin
                cmd_out        <= issue_cmd;
                bank_group_out <= head_addr.dev.bank_group;
                bank_out       <= head_addr.dev.bank;
                row_out        <= head_addr.dev.row;
                col_out        <= head_addr.dev.col;
            end
        end
    end

endmodule

//--- cmd_issue/bank_tracker.sv
`include "sched_cfg.svh"

module bank_tracker (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        open_strobe,
    input  logic                        close_strobe,
    input  logic [`SCHED_IDX_BITS-1:0]  bank_idx,
    input  logic [`SCHED_ROW_BITS-1:0]  row,
    output logic                        bank_open,
    output logic [`SCHED_ROW_BITS-1:0]  open_row
);

    localparam int BANKS = `SCHED_BANKS;

    logic [BANKS-1:0]           open_flags;       // one bit per bank
    logic [`SCHED_ROW_BITS-1:0] row_mem [BANKS];  // row held open in each bank

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_flags <= '0;
        end else begin
            if (open_strobe) begin
                open_flags[bank_idx] <= 1'b1;
            end else if (close_strobe) begin
                open_flags[bank_idx] <= 1'b0;
            end
        end
    end

    // row only matters while the flag is set
    always_ff @(posedge clk_in) begin
        if (open_strobe) begin
            row_mem[bank_idx] <= row;
        end
    end

    assign bank_open = open_flags[bank_idx];
    assign open_row  = row_mem[bank_idx];

endmodule

//--- hdl/request_queue.sv
`include "sched_cfg.svh"

module request_queue import sched_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         push,
    input  sched_addr_u                  push_addr,
    input  logic                         push_write,
    input  logic [`SCHED_DATA_BITS-1:0]  push_data,
    input  logic                         pop,
    output logic                         full,
    output logic                         empty,
    output sched_addr_u                  head_addr,
    output logic                         head_write,
    output logic [`SCHED_DATA_BITS-1:0]  head_data
);

    localparam int DEPTH    = `SCHED_QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    sched_addr_u                 addr_mem  [DEPTH];
    logic                        write_mem [DEPTH];
    logic [`SCHED_DATA_BITS-1:0] data_mem  [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    assign full  = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);

    // head is read straight from storage
    assign head_addr  = addr_mem[rd_ptr];
    assign head_write = write_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            addr_mem[wr_ptr]  <= push_addr;
            write_mem[wr_ptr] <= push_write;
            data_mem[wr_ptr]  <= push_data;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // push and pop together leave the count alone
        end
    end

endmodule

//--- hdl/request_intake.sv
`include "sched_cfg.svh"

module request_intake import sched_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         valid_in,
    input  logic [`SCHED_BG_BITS-1:0]    bank_group_in,
    input  logic [`SCHED_BANK_BITS-1:0]  bank_in,
    input  logic [`SCHED_ROW_BITS-1:0]   row_in,
    input  logic [`SCHED_COL_BITS-1:0]   col_in,
    input  logic                         write_in,
    input  logic [`SCHED_DATA_BITS-1:0]  val_in,
    input  logic                         full,
    output logic                         push,
    output sched_addr_u                  push_addr,
    output logic                         push_write,
    output logic [`SCHED_DATA_BITS-1:0]  push_data,
    output logic [7:0]                   dropped_count
);

    logic req_valid_q; // a request sits in the stage register

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= valid_in;
        end
    end

    // request payload, only meaningful while req_valid_q is high
    always_ff @(posedge clk_in) begin
        if (valid_in) begin
            push_addr.dev.bank_group <= bank_group_in;
            push_addr.dev.bank       <= bank_in;
            push_addr.dev.row        <= row_in;
            push_addr.dev.col        <= col_in;
            push_write               <= write_in;
            push_data                <= val_in;
        end
    end

    assign push = req_valid_q && !full;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            dropped_count <= '0;
        end else if (req_valid_q && full && dropped_count != 8'hff) begin
            dropped_count <= dropped_count + 8'd1; // saturates at 255
        end
    end

endmodule

//--- common/sched_pkg.sv
`include "sched_cfg.svh"

package sched_pkg;

    // one address word, read either per device field or per flat bank index
    // bank group sits above bank, so {bank_group, bank} is the flat index
    typedef union packed {
        struct packed {
            logic [`SCHED_BG_BITS-1:0]   bank_group;
            logic [`SCHED_BANK_BITS-1:0] bank;
            logic [`SCHED_ROW_BITS-1:0]  row;
            logic [`SCHED_COL_BITS-1:0]  col;
        } dev;
        struct packed {
            logic [`SCHED_IDX_BITS-1:0]  bank_idx;
            logic [`SCHED_ROW_BITS-1:0]  row;
            logic [`SCHED_COL_BITS-1:0]  col;
        } trk;
    } sched_addr_u;

endpackage

//--- common/sched_cfg.svh
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// bank layout, two groups of two banks
`define SCHED_BANK_GROUPS     2
`define SCHED_BANKS_PER_GROUP 2
`define SCHED_BANKS           (`SCHED_BANK_GROUPS * `SCHED_BANKS_PER_GROUP)
`define SCHED_BG_BITS         $clog2(`SCHED_BANK_GROUPS)
`define SCHED_BANK_BITS       $clog2(`SCHED_BANKS_PER_GROUP)
`define SCHED_IDX_BITS        $clog2(`SCHED_BANKS)

`define SCHED_ROW_BITS    8
`define SCHED_COL_BITS    4
`define SCHED_DATA_BITS   32
`define SCHED_QUEUE_DEPTH 8

`define SCHED_PRE_LATENCY 5 // precharge to activate
`define SCHED_ACT_LATENCY 8 // activate to read/write

`define SCHED_CMD_READ      3'd0
`define SCHED_CMD_WRITE     3'd1
`define SCHED_CMD_ACTIVATE  3'd2
`define SCHED_CMD_PRECHARGE 3'd3

`endif
